//--- source/tile_pkg.sv
`default_nettype none

package tile_pkg;

   // Bus geometry
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;
   localparam int SEL_WIDTH  = DATA_WIDTH / 8;  // One enable per byte lane

   // Byte address as seen on the bus
   typedef logic [ADDR_WIDTH-1:0] addr_t;

   // Full data word
   typedef logic [DATA_WIDTH-1:0] data_t;

   // Byte enables
   typedef logic [SEL_WIDTH-1:0]  sel_t;

   // Address map
   // Only the top bit decides between local memory and the error response.
   // Local memory covers 0x00000000 to 0x7fffffff.
   localparam int DM_MATCH_WIDTH = 1;
   localparam logic [DM_MATCH_WIDTH-1:0] DM_MATCH = 1'b0;  // Top bit clear

   // Memory arbiter states
   typedef enum logic [1:0] {
      ARB_IDLE,  // Memory free, waiting for a request
      ARB_BUS,   // Core-side bus owns the SRAM
      ARB_MAM    // Debug port owns the SRAM
   } arb_state_t;

endpackage

`default_nettype wire

//--- source/wb_if.sv
`default_nettype none

// Single-beat Wishbone, no burst or retry signals
interface wb_if;
   import tile_pkg::*;

   addr_t adr;    // Byte address
   data_t dat_w;  // Write data, master to slave
   sel_t  sel;    // Byte lane enables
   logic  we;     // Write when high
   logic  cyc;    // Cycle in progress
   logic  stb;    // Valid request
   data_t dat_r;  // Read data, valid with ack
   logic  ack;    // Normal completion, one cycle
   logic  err;    // Error completion, one cycle

   // Request side
   modport master (
      output adr, dat_w, sel, we, cyc, stb,
      input  dat_r, ack, err
   );

   // Response side
   modport slave (
      input  adr, dat_w, sel, we, cyc, stb,
      output dat_r, ack, err
   );

endinterface

`default_nettype wire

//--- source/tile_bus.sv
`default_nettype none

// Core-side address decoder
// DM range goes straight through, anything else is answered with err
module tile_bus (
   input  wire   clk,
   input  wire   reset_i,
   wb_if.slave   core,  // From the core-side master
   wb_if.master  dm     // Towards the memory arbiter
);
   import tile_pkg::*;

   logic dm_hit;     // Address inside local memory
   logic core_req;   // Core presents a valid request
   logic err_q;      // Pending error response

   // Decode on the top address bits only
   assign dm_hit   = (core.adr[ADDR_WIDTH-1 -: DM_MATCH_WIDTH] == DM_MATCH);
   assign core_req = core.cyc & core.stb;

   // Request path to local memory
   // Payload is forwarded as is
   assign dm.adr   = core.adr;
   assign dm.dat_w = core.dat_w;
   assign dm.sel   = core.sel;
   assign dm.we    = core.we;

   // Handshake only when the address hits
   assign dm.cyc = core.cyc & dm_hit;
   assign dm.stb = core.stb & dm_hit;

   // Unmapped access
   // The flag is set at the edge that samples the request and cleared at the
   // next one, so a request still held while err is high gets no second err.
   always_ff @(posedge clk) begin
      if (reset_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= core_req & ~dm_hit & ~err_q;  // One-cycle pulse
      end
   end

   // Response path back to the core
   assign core.dat_r = dm.dat_r;          // Only meaningful with ack
   assign core.ack   = dm.ack;            // Arbiter acks only the owner
   assign core.err   = dm.err | err_q;    // SRAM never errs, decoder may

endmodule

`default_nettype wire

//--- source/mem_access_arbiter.sv
`default_nettype none

// Shares the single-port SRAM between the core-side bus and the debug port
// Grant is held for one complete access, debug side wins a tie
module mem_access_arbiter (
   input  wire   clk,
   input  wire   reset_i,
   wb_if.slave   bus,  // Core side, through the decoder
   wb_if.slave   mam,  // Debug memory access port
   wb_if.master  mem   // Towards the SRAM
);
   import tile_pkg::*;

   arb_state_t state_q;
   arb_state_t state_nxt;

   logic bus_req;    // Core side asks for the memory
   logic mam_req;    // Debug side asks for the memory
   logic own_bus;    // Bus currently holds the grant
   logic own_mam;    // Debug port currently holds the grant
   logic mem_done;   // Access of the owner completes this cycle

   assign bus_req = bus.cyc & bus.stb;
   assign mam_req = mam.cyc & mam.stb;

   assign own_bus = (state_q == ARB_BUS);
   assign own_mam = (state_q == ARB_MAM);

   assign mem_done = mem.ack | mem.err;

   // Grant FSM
   always_comb begin
      state_nxt = state_q;
      case (state_q)
         ARB_IDLE: begin
            if (mam_req) begin
               state_nxt = ARB_MAM;  // Debug first on a tie
            end else if (bus_req) begin
               state_nxt = ARB_BUS;
            end
         end
         ARB_BUS: begin
            if (mem_done) begin
               state_nxt = ARB_IDLE;  // Owner drops stb at this edge
            end
         end
         ARB_MAM: begin
            if (mem_done) begin
               state_nxt = ARB_IDLE;
            end
         end
         default: state_nxt = ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q <= ARB_IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   // Request mux
   // Payload follows the debug port only while it owns the memory
   assign mem.adr   = own_mam ? mam.adr   : bus.adr;
   assign mem.dat_w = own_mam ? mam.dat_w : bus.dat_w;
   assign mem.sel   = own_mam ? mam.sel   : bus.sel;
   assign mem.we    = own_mam ? mam.we    : bus.we;

   // No handshake reaches the SRAM while idle
   assign mem.cyc = (own_bus & bus.cyc) | (own_mam & mam.cyc);
   assign mem.stb = (own_bus & bus.stb) | (own_mam & mam.stb);

   // Responses go to the owner only, the loser keeps waiting
   assign bus.dat_r = mem.dat_r;
   assign bus.ack   = own_bus & mem.ack;
   assign bus.err   = own_bus & mem.err;

   assign mam.dat_r = mem.dat_r;
   assign mam.ack   = own_mam & mem.ack;
   assign mam.err   = 1'b0;  // Debug port has no error path

endmodule

`default_nettype wire

//--- source/wb_sram.sv
`default_nettype none

// Single-port SRAM on Wishbone
// Word organised, byte writes via sel, registered ack
module wb_sram #(
   parameter int unsigned MEM_SIZE_BYTE = 4096  // Power of two, 64 or more
) (
   input  wire   clk,
   input  wire   reset_i,
   wb_if.slave   wb
);
   import tile_pkg::*;

   localparam int unsigned WORDS = MEM_SIZE_BYTE / SEL_WIDTH;
   localparam int unsigned AW    = $clog2(WORDS);  // Word index width
   localparam int unsigned LSB   = $clog2(SEL_WIDTH);  // Byte offset bits

   data_t mem [WORDS];  // Storage, no reset

   logic [AW-1:0] word_idx;
   logic          req;     // New request this cycle
   logic          ack_q;
   data_t         rdata_q;

   // Upper address bits are ignored, so the DM range wraps
   assign word_idx = wb.adr[AW+LSB-1:LSB];

   // ack_q masks the request still held during the ack cycle
   assign req = wb.cyc & wb.stb & ~ack_q;

   // Write, lane by lane
   always_ff @(posedge clk) begin
      if (req && wb.we) begin
         for (int b = 0; b < SEL_WIDTH; b++) begin
            if (wb.sel[b]) begin
               mem[word_idx][8*b +: 8] <= wb.dat_w[8*b +: 8];
            end
         end
      end
   end

   // Read data, registered alongside ack
   always_ff @(posedge clk) begin
      if (req) begin
         rdata_q <= mem[word_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;  // High for exactly one cycle
      end
   end

   assign wb.dat_r = rdata_q;
   assign wb.ack   = ack_q;
   assign wb.err   = 1'b0;  // Every address inside the array is valid

endmodule

`default_nettype wire

//--- source/tile_dm.sv
`default_nettype none

// Compute tile, distributed memory variant
// Core-side master and debug port share the local SRAM
module tile_dm #(
   parameter int unsigned MEM_SIZE_BYTE = 4096  // Local memory size
) (
   input  wire                    clk,
   input  wire                    reset_i,

   // Core-side Wishbone master
   input  wire tile_pkg::addr_t   wbm_adr_i,
   input  wire tile_pkg::data_t   wbm_dat_i,
   input  wire tile_pkg::sel_t    wbm_sel_i,
   input  wire                    wbm_we_i,
   input  wire                    wbm_cyc_i,
   input  wire                    wbm_stb_i,
   output tile_pkg::data_t        wbm_dat_o,
   output logic                   wbm_ack_o,
   output logic                   wbm_err_o,

   // Debug memory access port
   input  wire tile_pkg::addr_t   mam_adr_i,
   input  wire tile_pkg::data_t   mam_dat_i,
   input  wire tile_pkg::sel_t    mam_sel_i,
   input  wire                    mam_we_i,
   input  wire                    mam_cyc_i,
   input  wire                    mam_stb_i,
   output tile_pkg::data_t        mam_dat_o,
   output logic                   mam_ack_o
);

   wb_if bus_if ();  // Core master to decoder
   wb_if dm_if ();   // Decoder to arbiter
   wb_if mam_if ();  // Debug port to arbiter
   wb_if mem_if ();  // Arbiter to SRAM

   // Core side onto the bus interface
   assign bus_if.adr   = wbm_adr_i;
   assign bus_if.dat_w = wbm_dat_i;
   assign bus_if.sel   = wbm_sel_i;
   assign bus_if.we    = wbm_we_i;
   assign bus_if.cyc   = wbm_cyc_i;
   assign bus_if.stb   = wbm_stb_i;
   assign wbm_dat_o    = bus_if.dat_r;
   assign wbm_ack_o    = bus_if.ack;
   assign wbm_err_o    = bus_if.err;

   // Debug side, err is left inside the tile
   assign mam_if.adr   = mam_adr_i;
   assign mam_if.dat_w = mam_dat_i;
   assign mam_if.sel   = mam_sel_i;
   assign mam_if.we    = mam_we_i;
   assign mam_if.cyc   = mam_cyc_i;
   assign mam_if.stb   = mam_stb_i;
   assign mam_dat_o    = mam_if.dat_r;
   assign mam_ack_o    = mam_if.ack;

   tile_bus u_bus (
      .clk     (clk),
      .reset_i (reset_i),
      .core    (bus_if.slave),
      .dm      (dm_if.master)
   );

   mem_access_arbiter u_arb (
      .clk     (clk),
      .reset_i (reset_i),
      .bus     (dm_if.slave),
      .mam     (mam_if.slave),
      .mem     (mem_if.master)
   );

   wb_sram #(
      .MEM_SIZE_BYTE (MEM_SIZE_BYTE)
   ) u_ram (
      .clk     (clk),
      .reset_i (reset_i),
      .wb      (mem_if.slave)
   );

endmodule

`default_nettype wire

//--- test/tile_dm_assert.sv
`default_nettype none

// Wishbone protocol properties at the tile ports
module tile_dm_assert (
   input wire clk,
   input wire reset_i,
   input wire wbm_cyc_i,
   input wire wbm_stb_i,
   input wire wbm_ack_o,
   input wire wbm_err_o,
   input wire mam_cyc_i,
   input wire mam_stb_i,
   input wire mam_ack_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Exactly one kind of completion
   a_ack_err_excl: assert property (@(posedge clk) disable iff (reset_i)
      !(wbm_ack_o && wbm_err_o))
      else $error("wbm ack and err high in the same cycle");

   // Responses only to a live request
   a_bus_resp_stb: assert property (@(posedge clk) disable iff (reset_i)
      (wbm_ack_o || wbm_err_o) |-> (wbm_cyc_i && wbm_stb_i))
      else $error("core-side response without a request");

   a_mam_resp_stb: assert property (@(posedge clk) disable iff (reset_i)
      mam_ack_o |-> (mam_cyc_i && mam_stb_i))
      else $error("debug port ack without a request");

   // Single-port memory, one owner at a time
   a_ack_rise_excl: assert property (@(posedge clk) disable iff (reset_i)
      !($rose(mam_ack_o) && $rose(wbm_ack_o)))
      else $error("both ports acknowledged in the same cycle");

endmodule

bind tile_dm tile_dm_assert u_assert (
   .clk       (clk),
   .reset_i   (reset_i),
   .wbm_cyc_i (wbm_cyc_i),
   .wbm_stb_i (wbm_stb_i),
   .wbm_ack_o (wbm_ack_o),
   .wbm_err_o (wbm_err_o),
   .mam_cyc_i (mam_cyc_i),
   .mam_stb_i (mam_stb_i),
   .mam_ack_o (mam_ack_o)
);

`default_nettype wire

//--- test/tb_tile_dm.sv
`default_nettype none

// Testbench for the compute tile
// Accesses come from the case file, a local memory image gives expected data
module tb_tile_dm;
   timeunit 1ns;
   timeprecision 1ps;

   import tile_pkg::*;

   localparam int unsigned MEM_SIZE_BYTE  = 4096;
   localparam int          MEM_WORDS      = MEM_SIZE_BYTE / 4;
   localparam int          DRIVE_DLY      = 2;   // ns after the rising edge
   localparam int          TIMEOUT_CYCLES = 20;  // Worst case is well below this
   localparam logic [31:0] LFSR_SEED      = 32'h782a;

   logic  clk;
   logic  reset_i;
   addr_t wbm_adr_i;
   data_t wbm_dat_i;
   sel_t  wbm_sel_i;
   logic  wbm_we_i;
   logic  wbm_cyc_i;
   logic  wbm_stb_i;
   data_t wbm_dat_o;
   logic  wbm_ack_o;
   logic  wbm_err_o;
   addr_t mam_adr_i;
   data_t mam_dat_i;
   sel_t  mam_sel_i;
   logic  mam_we_i;
   logic  mam_cyc_i;
   logic  mam_stb_i;
   data_t mam_dat_o;
   logic  mam_ack_o;

   data_t       model [MEM_WORDS];  // Expected memory image
   logic [31:0] lfsr_q;
   int          bus_acks = 0;  // Ack pulses seen on each port
   int          mam_acks = 0;

   tile_dm #(
      .MEM_SIZE_BYTE (MEM_SIZE_BYTE)
   ) u_dut (
      .clk       (clk),
      .reset_i   (reset_i),
      .wbm_adr_i (wbm_adr_i),
      .wbm_dat_i (wbm_dat_i),
      .wbm_sel_i (wbm_sel_i),
      .wbm_we_i  (wbm_we_i),
      .wbm_cyc_i (wbm_cyc_i),
      .wbm_stb_i (wbm_stb_i),
      .wbm_dat_o (wbm_dat_o),
      .wbm_ack_o (wbm_ack_o),
      .wbm_err_o (wbm_err_o),
      .mam_adr_i (mam_adr_i),
      .mam_dat_i (mam_dat_i),
      .mam_sel_i (mam_sel_i),
      .mam_we_i  (mam_we_i),
      .mam_cyc_i (mam_cyc_i),
      .mam_stb_i (mam_stb_i),
      .mam_dat_o (mam_dat_o),
      .mam_ack_o (mam_ack_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   // Count each one-cycle pulse once, mid cycle
   always @(negedge clk) begin
      if (wbm_ack_o) bus_acks++;
      if (mam_ack_o) mam_acks++;
   end

   task automatic fail_run(input string what);
      $display("%s at %0t ns", what, $time);
      $display("Test failures found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
         $display("Test failures found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic data_t random_word();
      data_t w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr_q = lfsr_next(lfsr_q);  // One step per bit
         w = {w[30:0], lfsr_q[0]};
      end
      return w;
   endfunction

   // Addresses wrap modulo the memory size
   function automatic int model_index(input addr_t a);
      return int'((a & addr_t'(MEM_SIZE_BYTE - 1)) >> 2);
   endfunction

   function automatic void model_write(input addr_t a, input data_t d, input sel_t s);
      int idx;
      idx = model_index(a);
      for (int b = 0; b < 4; b++) begin
         if (s[b]) model[idx][8*b +: 8] = d[8*b +: 8];  // Enabled lanes only
      end
   endfunction

   task automatic bus_access(input addr_t adr, input data_t wdat, input sel_t sel,
         input logic we, output data_t rdat, output logic err, output time t_done);
      int   waited;
      logic done;
      waited = 0;
      done   = 1'b0;
      @(posedge clk);
      #DRIVE_DLY;
      wbm_adr_i = adr;
      wbm_dat_i = wdat;
      wbm_sel_i = sel;
      wbm_we_i  = we;
      wbm_cyc_i = 1'b1;
      wbm_stb_i = 1'b1;
      while (!done) begin
         @(negedge clk);
         if (wbm_ack_o || wbm_err_o) begin
            done   = 1'b1;
            rdat   = wbm_dat_o;
            err    = wbm_err_o;
            t_done = $time;
         end else if (waited == TIMEOUT_CYCLES) begin
            fail_run("bus access got neither ack nor err in time");
         end else begin
            waited++;
         end
      end
      @(posedge clk);  // Edge that sees the response
      #DRIVE_DLY;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
   endtask

   task automatic mam_access(input addr_t adr, input data_t wdat, input sel_t sel,
         input logic we, output data_t rdat, output time t_done);
      int   waited;
      logic done;
      waited = 0;
      done   = 1'b0;
      @(posedge clk);
      #DRIVE_DLY;
      mam_adr_i = adr;
      mam_dat_i = wdat;
      mam_sel_i = sel;
      mam_we_i  = we;
      mam_cyc_i = 1'b1;
      mam_stb_i = 1'b1;
      while (!done) begin
         @(negedge clk);
         if (mam_ack_o) begin
            done   = 1'b1;
            rdat   = mam_dat_o;
            t_done = $time;
         end else if (waited == TIMEOUT_CYCLES) begin
            fail_run("debug port access got no ack in time");
         end else begin
            waited++;
         end
      end
      @(posedge clk);
      #DRIVE_DLY;
      mam_cyc_i = 1'b0;
      mam_stb_i = 1'b0;
      mam_we_i  = 1'b0;
   endtask

   // No request, so nothing may answer
   task automatic idle_check(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         check_value("wbm_ack_o", {31'b0, wbm_ack_o}, 32'd0);
         check_value("wbm_err_o", {31'b0, wbm_err_o}, 32'd0);
         check_value("mam_ack_o", {31'b0, mam_ack_o}, 32'd0);
      end
   endtask

   task automatic single_access(input string port, input logic we, input string resp,
         input addr_t adr, input data_t wdat, input sel_t sel, input data_t exp);
      data_t rdat;
      logic  err;
      time   t;
      int    acks_before;
      string dname;
      err         = 1'b0;
      acks_before = bus_acks;
      dname       = (port == "bus") ? "wbm_dat_o" : "mam_dat_o";
      if (port == "bus") begin
         bus_access(adr, wdat, sel, we, rdat, err, t);
      end else if (port == "mam") begin
         mam_access(adr, wdat, sel, we, rdat, t);
      end else begin
         fail_run("unknown port in case file");
      end
      if (resp == "err") begin
         if (port != "bus") fail_run("error response expected on the debug port");
         check_value("wbm_err_o", {31'b0, err}, 32'd1);
         check_value("wbm_ack_o count", 32'(bus_acks - acks_before), 32'd0);  // Model untouched
      end else if (resp == "ack") begin
         if (port == "bus") begin
            check_value("wbm_err_o", {31'b0, err}, 32'd0);
         end
         if (we) begin
            model_write(adr, wdat, sel);
         end else begin
            check_value(dname, rdat, exp);
            check_value(dname, rdat, model[model_index(adr)]);
         end
      end else begin
         fail_run("unknown response kind in case file");
      end
   endtask

   // Debug port at adr, bus at the next word, same edge
   task automatic contention_access(input logic we, input addr_t adr, input data_t wdat,
         input sel_t sel, input data_t exp);
      data_t mam_rdat;
      data_t bus_rdat;
      logic  bus_err;
      time   mam_t;
      time   bus_t;
      int    mam_before;
      int    bus_before;
      mam_before = mam_acks;
      bus_before = bus_acks;
      fork
         mam_access(adr, wdat, sel, we, mam_rdat, mam_t);
         bus_access(adr + 32'd4, ~wdat, sel, we, bus_rdat, bus_err, bus_t);
      join
      repeat (2) @(negedge clk);  // Any late second pulse shows up here
      check_value("mam_ack_o count", 32'(mam_acks - mam_before), 32'd1);
      check_value("wbm_ack_o count", 32'(bus_acks - bus_before), 32'd1);
      check_value("wbm_err_o", {31'b0, bus_err}, 32'd0);
      check_value("mam_ack_o before wbm_ack_o", {31'b0, mam_t < bus_t}, 32'd1);
      if (we) begin
         model_write(adr, wdat, sel);
         model_write(adr + 32'd4, ~wdat, sel);
      end else begin
         check_value("mam_dat_o", mam_rdat, exp);
         check_value("mam_dat_o", mam_rdat, model[model_index(adr)]);
         check_value("wbm_dat_o", bus_rdat, model[model_index(adr + 32'd4)]);
      end
   endtask

   // Writes alternate between ports, then every word is read through both
   task automatic fill_and_check(input addr_t base, input int count);
      data_t rdat;
      data_t w;
      logic  err;
      time   t;
      addr_t a;
      for (int i = 0; i < count; i++) begin
         a = base + addr_t'(4 * i);
         w = random_word();
         if (i % 2 == 0) begin
            bus_access(a, w, 4'hf, 1'b1, rdat, err, t);
            check_value("wbm_err_o", {31'b0, err}, 32'd0);
         end else begin
            mam_access(a, w, 4'hf, 1'b1, rdat, t);
         end
         model_write(a, w, 4'hf);
      end
      for (int i = 0; i < count; i++) begin
         a = base + addr_t'(4 * i);
         bus_access(a, '0, 4'hf, 1'b0, rdat, err, t);
         check_value("wbm_dat_o", rdat, model[model_index(a)]);
         mam_access(a, '0, 4'hf, 1'b0, rdat, t);
         check_value("mam_dat_o", rdat, model[model_index(a)]);
      end
   endtask

   task automatic run_case(input string port, input string op, input string resp,
         input addr_t adr, input data_t wdat, input sel_t sel, input data_t exp);
      if (op == "idle") begin
         idle_check(int'(wdat));  // Data column holds the cycle count
      end else if (op == "fill") begin
         fill_and_check(adr, int'(wdat));
      end else if (op == "wr" || op == "rd") begin
         if (port == "both") contention_access(op == "wr", adr, wdat, sel, exp);
         else single_access(port, op == "wr", resp, adr, wdat, sel, exp);
      end else begin
         fail_run("unknown operation in case file");
      end
   endtask

   initial begin
      string line;
      string port_s;
      string op_s;
      string resp_s;
      addr_t f_adr;
      data_t f_wdat;
      data_t f_exp;
      sel_t  f_sel;
      int    fd;
      int    nread;
      int    n_cases;
      n_cases   = 0;
      lfsr_q    = LFSR_SEED;
      reset_i   = 1'b1;
      wbm_adr_i = '0;
      wbm_dat_i = '0;
      wbm_sel_i = '0;
      wbm_we_i  = 1'b0;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      mam_adr_i = '0;
      mam_dat_i = '0;
      mam_sel_i = '0;
      mam_we_i  = 1'b0;
      mam_cyc_i = 1'b0;
      mam_stb_i = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) model[i] = '0;
      repeat (2) @(posedge clk);
      #DRIVE_DLY;
      reset_i = 1'b0;

      fd = $fopen("test/tile_cases.txt", "r");
      if (fd == 0) fail_run("cannot open test/tile_cases.txt");
      while (!$feof(fd)) begin
         line  = "";
         nread = $fgets(line, fd);
         if (line.len() == 0 || line[0] == "#" || line[0] == 8'h0a) continue;  // Blank or note
         nread = $sscanf(line, "%s %s %s %h %h %h %h",
                         port_s, op_s, resp_s, f_adr, f_wdat, f_sel, f_exp);
         if (nread != 7) fail_run("malformed line in case file");
         run_case(port_s, op_s, resp_s, f_adr, f_wdat, f_sel, f_exp);
         n_cases++;
      end
      $fclose(fd);

      repeat (2) @(posedge clk);
      if (n_cases > 0) begin
         $display("All tests passed!");
      end else begin
         $display("case file held no accesses");
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tile_cases.txt
# port op resp addr wdata sel rdata  (hex; idle and fill keep a count in wdata)
# port bus, mam or both; op idle, wr, rd or fill; resp ack or err
both idle ack 00000000 00000008 0 00000000
bus wr ack 00000000 11223344 f 00000000
bus rd ack 00000000 00000000 f 11223344
bus wr ack 00000004 a5a5a5a5 f 00000000
bus wr ack 00000004 0000bb00 2 00000000
bus rd ack 00000004 00000000 f a5a5bba5
bus wr ack 00000008 deadbeef f 00000000
bus wr ack 00000008 77000000 8 00000000
bus rd ack 00000008 00000000 f 77adbeef
bus wr ack 00000010 cafef00d f 00000000
bus wr err 80000010 12345678 f 00000000
bus rd err fffffffc 00000000 f 00000000
bus rd ack 00000010 00000000 f cafef00d
mam wr ack 00000100 0badc0de f 00000000
bus rd ack 00000100 00000000 f 0badc0de
bus wr ack 00000104 13579bdf f 00000000
mam rd ack 00000104 00000000 f 13579bdf
mam wr ack 00001020 600df00d f 00000000
bus rd ack 00000020 00000000 f 600df00d
bus rd ack 7ffff020 00000000 f 600df00d
both wr ack 00000300 f0f0f0f0 f 00000000
both rd ack 00000300 00000000 f f0f0f0f0
bus rd ack 00000304 00000000 f 0f0f0f0f
both fill ack 00000400 00000040 f 00000000

//--- list.f
source/tile_pkg.sv
source/wb_if.sv
source/tile_bus.sv
source/mem_access_arbiter.sv
source/wb_sram.sv
source/tile_dm.sv
test/tile_dm_assert.sv
test/tb_tile_dm.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --assert --top-module tb_tile_dm -f list.f -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > "$LOG" 2>&1 \
   || echo "Test failures found" >> "$LOG"
cat "$LOG"
grep -q "Test failures found" "$LOG" && echo "FAIL" && exit 1
echo "PASS"
exit 0
